// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_usb_cmd_interpreter

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module "$TOP" -f vlog.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

// ==== src/acq_ctrl.sv ====
`timescale 1ns/10ps

module acq_ctrl (
  input  logic                       clk,
  input  logic                       reset_n,
  input  readout_cmd_pkg::cmd_op_s   op,
  output readout_cmd_pkg::acq_ctrl_s ctrl
);

  logic [2:0] pulses;

  assign pulses = {ctrl.clear_data_fifo, ctrl.param_load, ctrl.rst_cntb};

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl <= '0;
    end else begin
      // Single-cycle strobes
      ctrl.clear_data_fifo <= (op.op == readout_cmd_pkg::OP_CLEAR_FIFO);
      ctrl.param_load      <= (op.op == readout_cmd_pkg::OP_PARAM_LOAD);
      ctrl.rst_cntb        <= (op.op == readout_cmd_pkg::OP_RST_CNTB);

      // Acquisition level, held until stopped
      if (op.op == readout_cmd_pkg::OP_ACQ_START) begin
        ctrl.acq_start <= 1'b1;
      end else if (op.op == readout_cmd_pkg::OP_ACQ_STOP) begin
        ctrl.acq_start <= 1'b0;
      end
    end
  end

  // No strobe is ever stretched to a second cycle
  a_pulse_width: assert property (@(posedge clk) disable iff (!reset_n)
    (pulses != '0) |=> ((pulses & $past(pulses)) == '0));

endmodule

// ==== src/chn_dac_bank.sv ====
`timescale 1ns/10ps

module chn_dac_bank (
  input  logic                      clk,
  input  logic                      reset_n,
  input  readout_cmd_pkg::cmd_op_s  op,
  output readout_cmd_pkg::chn_dac_t bank
);

  readout_cmd_pkg::chn_idx_t chn;
  logic [3:0]                code;
  logic                      wr;

  // Channel from payload bits 9..4, DAC code from 3..0
  assign chn  = op.payload[9:4];
  assign code = op.payload[3:0];
  assign wr   = (op.op == readout_cmd_pkg::OP_CHN_DAC);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      bank <= '0;
    end else if (wr) begin
      bank[{chn, 2'b00} +: 4] <= code;
    end
  end

endmodule

// ==== src/cmd_fifo.sv ====
`timescale 1ns/10ps

module cmd_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       wr_valid,
  input  readout_cmd_pkg::cmd_word_t wr_data,
  output logic                       wr_ready,
  input  logic                       rd_en,
  output readout_cmd_pkg::cmd_word_t rd_data,
  output logic                       empty
);

  localparam int AW = $clog2(DEPTH);

  readout_cmd_pkg::cmd_word_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_write;

  assign wr_ready = (count != (AW+1)'(DEPTH));
  assign empty    = (count == '0);
  assign do_write = wr_valid && wr_ready;

  // Head word is visible without a read latency
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Reader must never pop an empty queue
  a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
    rd_en |-> !empty);

endmodule

// ==== src/cmd_sequencer.sv ====
`timescale 1ns/10ps

module cmd_sequencer (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       fifo_empty,
  input  readout_cmd_pkg::cmd_word_t fifo_word,
  output logic                       fifo_rd_en,
  output readout_cmd_pkg::cmd_op_s   op
);

  typedef enum logic {IDLE, POP} state_t;

  state_t state;

  ////////////////////////////////////////
  // Command word decode
  ////////////////////////////////////////
  function automatic readout_cmd_pkg::cmd_op_t decode_word(
    input readout_cmd_pkg::cmd_word_t w
  );
    readout_cmd_pkg::cmd_op_t d;
    d = readout_cmd_pkg::OP_NONE;
    case (w)
      readout_cmd_pkg::CMD_ACQ_START:   d = readout_cmd_pkg::OP_ACQ_START;
      readout_cmd_pkg::CMD_ACQ_STOP:    d = readout_cmd_pkg::OP_ACQ_STOP;
      readout_cmd_pkg::CMD_CLEAR_FIFO:  d = readout_cmd_pkg::OP_CLEAR_FIFO;
      readout_cmd_pkg::CMD_PARAM_LOAD:  d = readout_cmd_pkg::OP_PARAM_LOAD;
      readout_cmd_pkg::CMD_RST_CNTB:    d = readout_cmd_pkg::OP_RST_CNTB;
      readout_cmd_pkg::CMD_SC_SEL:      d = readout_cmd_pkg::OP_SC_SEL;
      readout_cmd_pkg::CMD_READ_SEL:    d = readout_cmd_pkg::OP_READ_SEL;
      readout_cmd_pkg::CMD_TRIG_OFF:    d = readout_cmd_pkg::OP_TRIG_OFF;
      readout_cmd_pkg::CMD_TRIG_ON:     d = readout_cmd_pkg::OP_TRIG_ON;
      readout_cmd_pkg::CMD_ACQ_MODE:    d = readout_cmd_pkg::OP_ACQ_MODE;
      readout_cmd_pkg::CMD_SCTEST_MODE: d = readout_cmd_pkg::OP_SCTEST_MODE;
      readout_cmd_pkg::CMD_SINGLE_CHN:  d = readout_cmd_pkg::OP_SINGLE_CHN;
      readout_cmd_pkg::CMD_ALL_CHN:     d = readout_cmd_pkg::OP_ALL_CHN;
      readout_cmd_pkg::CMD_CTEST_IN:    d = readout_cmd_pkg::OP_CTEST_IN;
      readout_cmd_pkg::CMD_PIN_IN:      d = readout_cmd_pkg::OP_PIN_IN;
      default: begin
        // Prefix commands, none overlaps an exact code above
        if (w[15:4] == readout_cmd_pkg::CMD_ASIC_NUM_PFX)
          d = readout_cmd_pkg::OP_ASIC_NUM;
        else if (w[15:8] == readout_cmd_pkg::CMD_CTEST_PFX)
          d = readout_cmd_pkg::OP_CTEST;
        else if (w[15:8] == readout_cmd_pkg::CMD_READ_REG_PFX)
          d = readout_cmd_pkg::OP_READ_REG;
        else if (w[15:8] == readout_cmd_pkg::CMD_HEADER_PFX)
          d = readout_cmd_pkg::OP_HEADER;
        else if (w[15:8] == readout_cmd_pkg::CMD_GAIN_SW_PFX)
          d = readout_cmd_pkg::OP_GAIN_SW;
        else if (w[15:10] == readout_cmd_pkg::CMD_DAC0_PFX)
          d = readout_cmd_pkg::OP_DAC0;
        else if (w[15:10] == readout_cmd_pkg::CMD_DAC1_PFX)
          d = readout_cmd_pkg::OP_DAC1;
        else if (w[15:10] == readout_cmd_pkg::CMD_DAC2_PFX)
          d = readout_cmd_pkg::OP_DAC2;
        else if (w[15:10] == readout_cmd_pkg::CMD_CHN_DAC_PFX)
          d = readout_cmd_pkg::OP_CHN_DAC;
        else if (w[15:8] == readout_cmd_pkg::CMD_TEST_CHN_PFX)
          d = readout_cmd_pkg::OP_TEST_CHN;
        else if (w[15:8] == readout_cmd_pkg::CMD_CPT_MAX_PFX)
          d = readout_cmd_pkg::OP_CPT_MAX;
      end
    endcase
    return d;
  endfunction

  // Pop only from IDLE, so words leave at most every second cycle
  assign fifo_rd_en = (state == IDLE) && !fifo_empty;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
      op    <= '{op: readout_cmd_pkg::OP_NONE, payload: '0};
    end else begin
      op.op <= readout_cmd_pkg::OP_NONE;
      case (state)
        IDLE: begin
          if (fifo_rd_en) begin
            op.op      <= decode_word(fifo_word);
            op.payload <= fifo_word[9:0];
            state      <= POP;
          end
        end
        POP:     state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  a_op_spacing: assert property (@(posedge clk) disable iff (!reset_n)
    (op.op != readout_cmd_pkg::OP_NONE) |=> (op.op == readout_cmd_pkg::OP_NONE));

endmodule

// ==== src/readout_cmd_pkg.sv ====
package readout_cmd_pkg;

  ////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////
  localparam int NUM_CHN = 64;

  typedef logic [15:0]            cmd_word_t;
  typedef logic [9:0]             cmd_payload_t;
  typedef logic [9:0]             dac_vth_t;
  typedef logic [5:0]             chn_idx_t;
  typedef logic [NUM_CHN-1:0]     chn_mask_t;
  // Channel 0 sits in the low nibble
  typedef logic [NUM_CHN*4-1:0]   chn_dac_t;
  typedef logic [15:0]            cpt_max_t;

  localparam cpt_max_t CPT_MAX_DEFAULT = 16'd10000;

  ////////////////////////////////////////
  // Host command codes
  ////////////////////////////////////////
  localparam cmd_word_t CMD_ACQ_START   = 16'hF0F0;
  localparam cmd_word_t CMD_ACQ_STOP    = 16'hF0F1;
  localparam cmd_word_t CMD_CLEAR_FIFO  = 16'hF0FA;
  localparam cmd_word_t CMD_SC_SEL      = 16'hA0A0;
  localparam cmd_word_t CMD_READ_SEL    = 16'hA0A1;
  localparam cmd_word_t CMD_RST_CNTB    = 16'hA7A1;
  localparam cmd_word_t CMD_TRIG_OFF    = 16'hA9A0;
  localparam cmd_word_t CMD_TRIG_ON     = 16'hA9A1;
  localparam cmd_word_t CMD_PARAM_LOAD  = 16'hD0A2;
  localparam cmd_word_t CMD_ACQ_MODE    = 16'hE0A0;
  localparam cmd_word_t CMD_SCTEST_MODE = 16'hE0A1;
  localparam cmd_word_t CMD_SINGLE_CHN  = 16'hE0B0;
  localparam cmd_word_t CMD_ALL_CHN     = 16'hE0B1;
  localparam cmd_word_t CMD_CTEST_IN    = 16'hE0C0;
  localparam cmd_word_t CMD_PIN_IN      = 16'hE0C1;

  // Prefix codes, payload in the low bits
  localparam logic [11:0] CMD_ASIC_NUM_PFX = 12'hA0B;
  localparam logic [7:0]  CMD_CTEST_PFX    = 8'hA1;
  localparam logic [7:0]  CMD_READ_REG_PFX = 8'hA2;
  localparam logic [7:0]  CMD_HEADER_PFX   = 8'hAB;
  localparam logic [7:0]  CMD_GAIN_SW_PFX  = 8'hB3;
  localparam logic [5:0]  CMD_DAC0_PFX     = 6'h30;
  localparam logic [5:0]  CMD_DAC1_PFX     = 6'h31;
  localparam logic [5:0]  CMD_DAC2_PFX     = 6'h32;
  // CC00..CFFF, channel in bits 9..4
  localparam logic [5:0]  CMD_CHN_DAC_PFX  = 6'h33;
  localparam logic [7:0]  CMD_TEST_CHN_PFX = 8'hE1;
  localparam logic [7:0]  CMD_CPT_MAX_PFX  = 8'hE2;

  ////////////////////////////////////////
  // Decoded operations and outputs
  ////////////////////////////////////////
  typedef enum logic [4:0] {
    OP_NONE, OP_ACQ_START, OP_ACQ_STOP,
    OP_CLEAR_FIFO, OP_PARAM_LOAD, OP_RST_CNTB,
    OP_SC_SEL, OP_READ_SEL, OP_ASIC_NUM,
    OP_DAC0, OP_DAC1, OP_DAC2,
    OP_CTEST, OP_READ_REG, OP_TRIG_OFF, OP_TRIG_ON,
    OP_HEADER, OP_GAIN_SW, OP_CHN_DAC,
    OP_ACQ_MODE, OP_SCTEST_MODE, OP_SINGLE_CHN, OP_ALL_CHN,
    OP_CTEST_IN, OP_PIN_IN, OP_TEST_CHN, OP_CPT_MAX
  } cmd_op_t;

  typedef struct packed {
    cmd_op_t      op;
    cmd_payload_t payload;
  } cmd_op_s;

  typedef struct packed {
    logic acq_start;
    logic clear_data_fifo;
    logic param_load;
    logic rst_cntb;
  } acq_ctrl_s;

  typedef struct packed {
    logic       sc_or_read;
    logic [2:0] asic_num;
    dac_vth_t   dac0_vth;
    dac_vth_t   dac1_vth;
    dac_vth_t   dac2_vth;
    chn_mask_t  ctest;
    chn_mask_t  read_reg;
    logic       trig_en;
    logic [7:0] header;
    logic [1:0] sw_hg;
    logic [1:0] sw_lg;
  } sc_param_s;

  typedef struct packed {
    logic     acq_or_sctest;
    logic     single_or_64chn;
    logic     ctest_or_input;
    chn_idx_t test_chn;
    cpt_max_t cpt_max;
  } scurve_cfg_s;

endpackage

// ==== src/sc_param_regs.sv ====
`timescale 1ns/10ps

module sc_param_regs (
  input  logic                       clk,
  input  logic                       reset_n,
  input  readout_cmd_pkg::cmd_op_s   op,
  output readout_cmd_pkg::sc_param_s param
);

  localparam readout_cmd_pkg::sc_param_s PARAM_RESET = '{
    sc_or_read: 1'b0,
    asic_num:   3'd1,
    dac0_vth:   10'd1,
    dac1_vth:   10'd1,
    dac2_vth:   10'd1,
    ctest:      '0,
    read_reg:   '0,
    trig_en:    1'b0,
    header:     8'h55,
    sw_hg:      2'b01,
    sw_lg:      2'b01
  };

  // Code k in 1..64 selects channel k-1, 0xFF is all or none
  function automatic readout_cmd_pkg::chn_mask_t one_hot_mask(
    input logic [7:0] code,
    input logic       all_on_ff
  );
    readout_cmd_pkg::chn_mask_t m;
    m = '0;
    if (code >= 8'd1 && code <= 8'd64) begin
      m[6'(code - 8'd1)] = 1'b1;
    end else if (code == 8'hFF && all_on_ff) begin
      m = '1;
    end
    return m;
  endfunction

  ////////////////////////////////////////
  // Parameter updates
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      param <= PARAM_RESET;
    end else begin
      case (op.op)
        readout_cmd_pkg::OP_SC_SEL:   param.sc_or_read <= 1'b0;
        readout_cmd_pkg::OP_READ_SEL: param.sc_or_read <= 1'b1;
        readout_cmd_pkg::OP_ASIC_NUM: param.asic_num <= op.payload[2:0];
        // ASIC shifts thresholds LSB first
        readout_cmd_pkg::OP_DAC0:     param.dac0_vth <= {<<{op.payload}};
        readout_cmd_pkg::OP_DAC1:     param.dac1_vth <= {<<{op.payload}};
        readout_cmd_pkg::OP_DAC2:     param.dac2_vth <= {<<{op.payload}};
        readout_cmd_pkg::OP_CTEST: begin
          param.ctest <= one_hot_mask(op.payload[7:0], 1'b1);
        end
        readout_cmd_pkg::OP_READ_REG: begin
          param.read_reg <= one_hot_mask(op.payload[7:0], 1'b0);
        end
        readout_cmd_pkg::OP_TRIG_OFF: param.trig_en <= 1'b0;
        readout_cmd_pkg::OP_TRIG_ON:  param.trig_en <= 1'b1;
        readout_cmd_pkg::OP_HEADER:   param.header <= {<<{op.payload[7:0]}};
        readout_cmd_pkg::OP_GAIN_SW: begin
          // Bit 0 of each switch goes out first
          param.sw_hg <= {op.payload[4], op.payload[5]};
          param.sw_lg <= {op.payload[0], op.payload[1]};
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== src/scurve_cfg_regs.sv ====
`timescale 1ns/10ps

module scurve_cfg_regs (
  input  logic                         clk,
  input  logic                         reset_n,
  input  readout_cmd_pkg::cmd_op_s     op,
  output readout_cmd_pkg::scurve_cfg_s cfg
);

  // Max-count table, unknown codes fall back to the default
  function automatic readout_cmd_pkg::cpt_max_t cpt_lookup(input logic [7:0] sel);
    readout_cmd_pkg::cpt_max_t v;
    case (sel)
      8'd0:    v = 16'd200;
      8'd1:    v = 16'd1000;
      8'd2:    v = 16'd2000;
      8'd3:    v = 16'd5000;
      8'd4:    v = 16'd10000;
      8'd5:    v = 16'd20000;
      8'd6:    v = 16'd40000;
      8'd7:    v = 16'd50000;
      default: v = readout_cmd_pkg::CPT_MAX_DEFAULT;
    endcase
    return v;
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg.acq_or_sctest   <= 1'b1;
      cfg.single_or_64chn <= 1'b1;
      cfg.ctest_or_input  <= 1'b1;
      cfg.test_chn        <= '0;
      cfg.cpt_max         <= readout_cmd_pkg::CPT_MAX_DEFAULT;
    end else begin
      case (op.op)
        readout_cmd_pkg::OP_ACQ_MODE:    cfg.acq_or_sctest <= 1'b1;
        readout_cmd_pkg::OP_SCTEST_MODE: cfg.acq_or_sctest <= 1'b0;
        readout_cmd_pkg::OP_SINGLE_CHN:  cfg.single_or_64chn <= 1'b1;
        readout_cmd_pkg::OP_ALL_CHN:     cfg.single_or_64chn <= 1'b0;
        readout_cmd_pkg::OP_CTEST_IN:    cfg.ctest_or_input <= 1'b1;
        readout_cmd_pkg::OP_PIN_IN:      cfg.ctest_or_input <= 1'b0;
        readout_cmd_pkg::OP_TEST_CHN:    cfg.test_chn <= op.payload[5:0];
        readout_cmd_pkg::OP_CPT_MAX:     cfg.cpt_max <= cpt_lookup(op.payload[7:0]);
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== src/usb_cmd_interpreter.sv ====
`timescale 1ns/10ps

module usb_cmd_interpreter #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         cmd_valid,
  input  readout_cmd_pkg::cmd_word_t   cmd_word,
  output logic                         cmd_ready,
  output readout_cmd_pkg::acq_ctrl_s   acq_ctrl,
  output readout_cmd_pkg::sc_param_s   sc_param,
  output readout_cmd_pkg::chn_dac_t    chn_dac,
  output readout_cmd_pkg::scurve_cfg_s scurve_cfg
);

  logic                       fifo_empty;
  logic                       fifo_rd_en;
  readout_cmd_pkg::cmd_word_t fifo_word;
  readout_cmd_pkg::cmd_op_s   op;

  ////////////////////////////////////////
  // Command path
  ////////////////////////////////////////
  cmd_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk      (clk),
    .reset_n  (reset_n),
    .wr_valid (cmd_valid),
    .wr_data  (cmd_word),
    .wr_ready (cmd_ready),
    .rd_en    (fifo_rd_en),
    .rd_data  (fifo_word),
    .empty    (fifo_empty)
  );

  cmd_sequencer u_cmd_sequencer (
    .clk        (clk),
    .reset_n    (reset_n),
    .fifo_empty (fifo_empty),
    .fifo_word  (fifo_word),
    .fifo_rd_en (fifo_rd_en),
    .op         (op)
  );

  ////////////////////////////////////////
  // Register blocks on the op broadcast
  ////////////////////////////////////////
  acq_ctrl u_acq_ctrl (
    .clk     (clk),
    .reset_n (reset_n),
    .op      (op),
    .ctrl    (acq_ctrl)
  );

  sc_param_regs u_sc_param_regs (
    .clk     (clk),
    .reset_n (reset_n),
    .op      (op),
    .param   (sc_param)
  );

  chn_dac_bank u_chn_dac_bank (
    .clk     (clk),
    .reset_n (reset_n),
    .op      (op),
    .bank    (chn_dac)
  );

  scurve_cfg_regs u_scurve_cfg_regs (
    .clk     (clk),
    .reset_n (reset_n),
    .op      (op),
    .cfg     (scurve_cfg)
  );

endmodule

// ==== testbench/tb_usb_cmd_interpreter.sv ====
`timescale 1ns/10ps

module tb_usb_cmd_interpreter;

  localparam int FIFO_DEPTH = 16;
  // Worst-case latency from acceptance to output with a full FIFO
  localparam int SETTLE_CYCLES = 2 * FIFO_DEPTH + 3;
  // About ten times the length of the whole sequence
  localparam int TIMEOUT_CYCLES = 20000;

  logic                                 clk;
  logic                                 reset_n;
  logic                                 cmd_valid;
  readout_cmd_pkg::cmd_word_t           cmd_word;
  logic                                 cmd_ready;
  readout_cmd_pkg::acq_ctrl_s           acq_ctrl;
  readout_cmd_pkg::sc_param_s           sc_param;
  readout_cmd_pkg::chn_dac_t            chn_dac;
  readout_cmd_pkg::scurve_cfg_s         scurve_cfg;

  // Reference model state
  readout_cmd_pkg::sc_param_s   m_sc;
  readout_cmd_pkg::scurve_cfg_s m_scurve;
  readout_cmd_pkg::chn_dac_t    m_dac;
  logic                         m_acq;
  int exp_clear;
  int exp_load;
  int exp_rst;

  // Monitor state
  int obs_clear;
  int obs_load;
  int obs_rst;
  logic [2:0] prev_pulses;
  logic saw_full;
  int cycle_count;
  logic [31:0] lfsr_state;

  usb_cmd_interpreter #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .cmd_ready  (cmd_ready),
    .acq_ctrl   (acq_ctrl),
    .sc_param   (sc_param),
    .chn_dac    (chn_dac),
    .scurve_cfg (scurve_cfg)
  );

  always #4 clk = ~clk;

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////
  // Polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic readout_cmd_pkg::cmd_word_t random_cmd();
    logic [3:0]                 kind;
    logic [31:0]                r;
    readout_cmd_pkg::cmd_word_t w;
    r = rand_bits(4);
    kind = r[3:0];
    r = rand_bits(10);
    case (kind)
      4'd0:  w = {12'hF0F, 3'b000, r[0]};
      4'd1:  w = {8'hA1, r[7:0]};
      4'd2:  w = {8'hA2, r[7:0]};
      4'd3:  w = {12'hA0B, 1'b0, r[2:0]};
      4'd4:  w = {6'h30, r[9:0]};
      4'd5:  w = {6'h31, r[9:0]};
      4'd6:  w = {6'h32, r[9:0]};
      4'd7:  w = {8'hAB, r[7:0]};
      4'd8:  w = {8'hB3, r[7:0]};
      4'd9:  w = {6'h33, r[9:0]};
      4'd10: w = {8'hE1, 2'b00, r[5:0]};
      4'd11: w = {8'hE2, 4'h0, r[3:0]};
      4'd12: begin
        w = 16'hA7A1;
        if (r[1:0] == 2'd0) w = 16'hF0FA;
        else if (r[1:0] == 2'd1) w = 16'hD0A2;
      end
      4'd13: w = {12'hA9A, 3'b000, r[0]};
      4'd14: begin
        w = {12'hE0A, 3'b000, r[0]};
        if (r[2:1] == 2'd1) w[7:4] = 4'hB;
        else if (r[2:1] == 2'd2) w[7:4] = 4'hC;
      end
      default: w = {12'hA0A, 3'b000, r[0]};
    endcase
    return w;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  task automatic model_reset();
    m_sc.sc_or_read = 1'b0;
    m_sc.asic_num   = 3'd1;
    m_sc.dac0_vth   = 10'd1;
    m_sc.dac1_vth   = 10'd1;
    m_sc.dac2_vth   = 10'd1;
    m_sc.ctest      = '0;
    m_sc.read_reg   = '0;
    m_sc.trig_en    = 1'b0;
    m_sc.header     = 8'h55;
    m_sc.sw_hg      = 2'b01;
    m_sc.sw_lg      = 2'b01;
    m_scurve.acq_or_sctest   = 1'b1;
    m_scurve.single_or_64chn = 1'b1;
    m_scurve.ctest_or_input  = 1'b1;
    m_scurve.test_chn        = '0;
    m_scurve.cpt_max         = 16'd10000;
    m_dac = '0;
    m_acq = 1'b0;
    exp_clear = 0;
    exp_load  = 0;
    exp_rst   = 0;
  endtask

  function automatic void model_apply(input readout_cmd_pkg::cmd_word_t w);
    logic [9:0] rev;
    logic [7:0] k;
    logic [2:0] cpt_sel;
    k = w[7:0];
    for (int i = 0; i < 10; i++) rev[i] = w[9 - i];
    if (w == 16'hF0F0) m_acq = 1'b1;
    else if (w == 16'hF0F1) m_acq = 1'b0;
    else if (w == 16'hF0FA) exp_clear++;
    else if (w == 16'hD0A2) exp_load++;
    else if (w == 16'hA7A1) exp_rst++;
    else if (w == 16'hA0A0) m_sc.sc_or_read = 1'b0;
    else if (w == 16'hA0A1) m_sc.sc_or_read = 1'b1;
    else if (w == 16'hA9A0) m_sc.trig_en = 1'b0;
    else if (w == 16'hA9A1) m_sc.trig_en = 1'b1;
    else if (w == 16'hE0A0) m_scurve.acq_or_sctest = 1'b1;
    else if (w == 16'hE0A1) m_scurve.acq_or_sctest = 1'b0;
    else if (w == 16'hE0B0) m_scurve.single_or_64chn = 1'b1;
    else if (w == 16'hE0B1) m_scurve.single_or_64chn = 1'b0;
    else if (w == 16'hE0C0) m_scurve.ctest_or_input = 1'b1;
    else if (w == 16'hE0C1) m_scurve.ctest_or_input = 1'b0;
    else if (w[15:4] == 12'hA0B) m_sc.asic_num = w[2:0];
    else if (w[15:8] == 8'hA1) begin
      // Channel i is on for code i+1, every channel for FF
      for (int i = 0; i < readout_cmd_pkg::NUM_CHN; i++) begin
        m_sc.ctest[i] = (int'(k) == i + 1) || (k == 8'hFF);
      end
    end
    else if (w[15:8] == 8'hA2) begin
      for (int i = 0; i < readout_cmd_pkg::NUM_CHN; i++) begin
        m_sc.read_reg[i] = (int'(k) == i + 1);
      end
    end
    else if (w[15:8] == 8'hAB) m_sc.header = rev[9:2];
    else if (w[15:8] == 8'hB3) begin
      m_sc.sw_hg = {w[4], w[5]};
      m_sc.sw_lg = {w[0], w[1]};
    end
    else if (w[15:10] == 6'h30) m_sc.dac0_vth = rev;
    else if (w[15:10] == 6'h31) m_sc.dac1_vth = rev;
    else if (w[15:10] == 6'h32) m_sc.dac2_vth = rev;
    else if (w[15:10] == 6'h33) m_dac[int'(w[9:4]) * 4 +: 4] = w[3:0];
    else if (w[15:8] == 8'hE1) m_scurve.test_chn = w[5:0];
    else if (w[15:8] == 8'hE2) begin
      cpt_sel = k[2:0];
      if (k > 8'd7) m_scurve.cpt_max = 16'd10000;
      else if (cpt_sel == 3'd0) m_scurve.cpt_max = 16'd200;
      else if (cpt_sel == 3'd1) m_scurve.cpt_max = 16'd1000;
      else if (cpt_sel == 3'd2) m_scurve.cpt_max = 16'd2000;
      else if (cpt_sel == 3'd3) m_scurve.cpt_max = 16'd5000;
      else if (cpt_sel == 3'd4) m_scurve.cpt_max = 16'd10000;
      else if (cpt_sel == 3'd5) m_scurve.cpt_max = 16'd20000;
      else if (cpt_sel == 3'd6) m_scurve.cpt_max = 16'd40000;
      else m_scurve.cpt_max = 16'd50000;
    end
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_sc(input readout_cmd_pkg::sc_param_s got,
                          input readout_cmd_pkg::sc_param_s exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH sc_param: got %h expected %h", got, exp));
  endtask

  task automatic check_scurve(input readout_cmd_pkg::scurve_cfg_s got,
                              input readout_cmd_pkg::scurve_cfg_s exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH scurve_cfg: got %h expected %h", got, exp));
  endtask

  task automatic check_dac(input readout_cmd_pkg::chn_dac_t got,
                           input readout_cmd_pkg::chn_dac_t exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH chn_dac: got %h expected %h", got, exp));
  endtask

  task automatic check_acq(input readout_cmd_pkg::acq_ctrl_s got,
                           input readout_cmd_pkg::acq_ctrl_s exp);
    if (got !== exp)
      stop_on_error($sformatf("MISMATCH acq_ctrl: got %h expected %h", got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_all();
    readout_cmd_pkg::acq_ctrl_s exp_ctrl;
    exp_ctrl = '0;
    exp_ctrl.acq_start = m_acq;
    check_sc(sc_param, m_sc);
    check_scurve(scurve_cfg, m_scurve);
    check_dac(chn_dac, m_dac);
    check_acq(acq_ctrl, exp_ctrl);
    check_count("clear_data_fifo pulses", obs_clear, exp_clear);
    check_count("param_load pulses", obs_load, exp_load);
    check_count("rst_cntb pulses", obs_rst, exp_rst);
  endtask

  ////////////////////////////////////////
  // Host side driver
  ////////////////////////////////////////
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Holds the word until the FIFO takes it
  task automatic send_word(input readout_cmd_pkg::cmd_word_t w);
    cmd_valid = 1'b1;
    cmd_word  = w;
    @(negedge clk);
    while (!cmd_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    model_apply(w);
  endtask

  task automatic settle_and_check();
    idle_cycles(SETTLE_CYCLES);
    check_all();
  endtask

  // Pulse monitor and back-pressure flag sampled mid-cycle
  always @(negedge clk) begin
    if (reset_n) begin
      if (acq_ctrl.clear_data_fifo) obs_clear++;
      if (acq_ctrl.param_load) obs_load++;
      if (acq_ctrl.rst_cntb) obs_rst++;
      if ((prev_pulses & {acq_ctrl.clear_data_fifo, acq_ctrl.param_load,
                          acq_ctrl.rst_cntb}) != 3'b000)
        stop_on_error("A control pulse stayed high for more than one cycle");
      prev_pulses = {acq_ctrl.clear_data_fifo, acq_ctrl.param_load, acq_ctrl.rst_cntb};
      if (cmd_valid && !cmd_ready) saw_full = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_on_error($sformatf("Timeout after %0d cycles, test sequence did not finish",
                              TIMEOUT_CYCLES));
  end

  initial begin
    logic [31:0] r;
    clk         = 1'b0;
    reset_n     = 1'b0;
    cmd_valid   = 1'b0;
    cmd_word    = '0;
    lfsr_state  = 32'h44861b0e;
    obs_clear   = 0;
    obs_load    = 0;
    obs_rst     = 0;
    prev_pulses = 3'b000;
    saw_full    = 1'b0;
    cycle_count = 0;
    model_reset();
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // Reset values
    idle_cycles(2);
    check_all();
    if (cmd_ready !== 1'b1)
      stop_on_error($sformatf("MISMATCH cmd_ready: got %h expected %h", cmd_ready, 1'b1));

    // Acquisition level and pulses
    send_word(16'hF0F0);
    settle_and_check();
    send_word(16'hF0FA);
    send_word(16'hD0A2);
    send_word(16'hA7A1);
    idle_cycles(3);
    send_word(16'hF0FA);
    send_word(16'hA7A1);
    settle_and_check();
    send_word(16'hF0F1);
    settle_and_check();

    // Slow-control parameters
    r = rand_bits(10);
    send_word({6'h30, r[9:0]});
    r = rand_bits(10);
    send_word({6'h31, r[9:0]});
    r = rand_bits(10);
    send_word({6'h32, r[9:0]});
    r = rand_bits(8);
    send_word({8'hAB, r[7:0]});
    send_word(16'hB312);
    send_word(16'hA0B5);
    send_word(16'hA9A1);
    send_word(16'hA0A1);
    settle_and_check();
    send_word(16'hB321);
    send_word(16'hA9A0);
    settle_and_check();
    send_word(16'hA101);
    settle_and_check();
    send_word(16'hA140);
    settle_and_check();
    send_word(16'hA141);
    settle_and_check();
    send_word(16'hA1FF);
    settle_and_check();
    // Code 0 has to clear a full mask
    send_word(16'hA100);
    settle_and_check();
    send_word(16'hA201);
    settle_and_check();
    send_word(16'hA240);
    settle_and_check();
    send_word(16'hA2FF);
    settle_and_check();

    // Channel DAC bank with both end channels and random ones
    send_word({6'h33, 6'd0, 4'hA});
    send_word({6'h33, 6'd63, 4'h5});
    repeat (30) begin
      r = rand_bits(10);
      send_word({6'h33, r[9:0]});
      r = rand_bits(2);
      idle_cycles(int'(r[1:0]));
    end
    settle_and_check();

    // S-curve settings
    send_word(16'hE0A1);
    send_word(16'hE0B1);
    send_word(16'hE0C1);
    r = rand_bits(6);
    send_word({8'hE1, 2'b00, r[5:0]});
    settle_and_check();
    send_word(16'hE0A0);
    send_word(16'hE0B0);
    send_word(16'hE0C0);
    send_word(16'hE13F);
    settle_and_check();
    for (int c = 0; c < 8; c++) begin
      send_word({8'hE2, 8'(c)});
      settle_and_check();
    end
    send_word(16'hE22A);
    settle_and_check();

    // Back-pressure burst with valid held every cycle
    saw_full = 1'b0;
    repeat (40) begin
      send_word(random_cmd());
    end
    settle_and_check();
    if (!saw_full)
      stop_on_error("cmd_ready never went low during the 40-word burst");

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/readout_cmd_pkg.sv
src/cmd_fifo.sv
src/cmd_sequencer.sv
src/acq_ctrl.sv
src/sc_param_regs.sv
src/chn_dac_bank.sv
src/scurve_cfg_regs.sv
src/usb_cmd_interpreter.sv
testbench/tb_usb_cmd_interpreter.sv
